/* include/mips_cfg.svh */
// configuration macros for the mips control path
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// data bus and register word width
`define MIPS_DATA_W 32

// state entered on reset (a cpu_state_t literal)
`define MIPS_RESET_STATE FETCH

`endif

/* hdl/mips_isa_pkg.sv */
// instruction set package naming the mips-i opcodes, function codes and regimm rt codes
`default_nettype none

package mips_isa_pkg;

  // primary opcode in instr[31:26]
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'd0,   // r-type, see funct_t
    OP_REGIMM  = 6'd1,   // see regimm_t
    OP_J       = 6'd2,
    OP_JAL     = 6'd3,
    OP_BEQ     = 6'd4,
    OP_BNE     = 6'd5,
    OP_BLEZ    = 6'd6,
    OP_BGTZ    = 6'd7,
    OP_ADDIU   = 6'd9,
    OP_SLTI    = 6'd10,
    OP_SLTIU   = 6'd11,
    OP_ANDI    = 6'd12,  // zero extended imm
    OP_ORI     = 6'd13,
    OP_XORI    = 6'd14,
    OP_LUI     = 6'd15,
    OP_LB      = 6'd32,
    OP_LH      = 6'd33,
    OP_LWL     = 6'd34,
    OP_LW      = 6'd35,
    OP_LBU     = 6'd36,
    OP_LHU     = 6'd37,
    OP_LWR     = 6'd38,
    OP_SB      = 6'd40,
    OP_SH      = 6'd41,
    OP_SW      = 6'd43
  } opcode_t;

  // special function field in instr[5:0]
  // only the codes the decoder singles out are named
  typedef enum logic [5:0] {
    FN_JR    = 6'd8,
    FN_JALR  = 6'd9,
    FN_MFHI  = 6'd16,
    FN_MTHI  = 6'd17,
    FN_MFLO  = 6'd18,
    FN_MTLO  = 6'd19,
    FN_MULT  = 6'd24,
    FN_MULTU = 6'd25,
    FN_DIV   = 6'd26,
    FN_DIVU  = 6'd27
  } funct_t;

  // regimm branch kind in the rt field, instr[20:16]
  typedef enum logic [4:0] {
    RI_BLTZ   = 5'd0,
    RI_BGEZ   = 5'd1,
    RI_BLTZAL = 5'd16,   // links to r31
    RI_BGEZAL = 5'd17
  } regimm_t;

endpackage

`default_nettype wire

/* hdl/mips_ctrl_pkg.sv */
// control path package with the cpu state, alu class, store lane and load form types
`default_nettype none

package mips_ctrl_pkg;

  // multicycle sequence of one instruction
  typedef enum logic [2:0] {
    FETCH = 3'd0,
    LOAD  = 3'd1,   // ir loaded
    MEM   = 3'd2,
    EXEC  = 3'd3,
    HALT  = 3'd4    // only reached from a corrupted state
  } cpu_state_t;

  // class handed to the alu controller
  typedef enum logic [1:0] {
    ALU_ADDR   = 2'd0,  // load/store address add
    ALU_BRANCH = 2'd1,  // beq/bne compare
    ALU_RTYPE  = 2'd2,
    ALU_ITYPE  = 2'd3
  } alu_op_t;

  // byte lane placement of store data
  typedef enum logic [2:0] {
    WD_WORD = 3'd0,
    WD_B0   = 3'd1,
    WD_B1   = 3'd2,
    WD_B2   = 3'd3,
    WD_B3   = 3'd4,
    WD_H0   = 3'd5,   // low half
    WD_H1   = 3'd6    // high half
  } wdata_sel_t;

  // form of the value written back by a load
  typedef enum logic [2:0] {
    LD_NONE  = 3'd0,
    LD_WORD  = 3'd1,  // lw, also lwl/lwr
    LD_BYTE  = 3'd2,
    LD_BYTEU = 3'd3,
    LD_HALF  = 3'd4,
    LD_HALFU = 3'd5
  } load_sel_t;

endpackage

`default_nettype wire

/* hdl/cpu_state_fsm.sv */
// state sequencer stepping fetch, load, mem and exec and holding the instruction register
`default_nettype none
`include "mips_cfg.svh"

module cpu_state_fsm import mips_ctrl_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    waitrequest,  // slave stall
  input  logic [`MIPS_DATA_W-1:0] readdata,
  input  logic                    read,         // decoded bus command
  input  logic                    write,
  output cpu_state_t              state,
  output logic [31:0]             instr,
  output logic                    mdr_load      // capture load data
);

  cpu_state_t state_next;
  logic       ir_load;
  logic       mem_busy;

  assign ir_load  = (state == FETCH) && !waitrequest;  // fetch completes
  assign mem_busy = (read || write) && waitrequest;    // access still stalled
  assign mdr_load = (state == MEM) && read && !waitrequest;

  always_comb begin
    case (state)
      FETCH:   state_next = waitrequest ? FETCH : LOAD;
      LOAD:    state_next = MEM;
      MEM:     state_next = mem_busy ? MEM : EXEC;  // one cycle when no access
      EXEC:    state_next = FETCH;
      default: state_next = HALT;                   // halt stays until reset
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= `MIPS_RESET_STATE;
      instr <= '0;
    end else begin
      state <= state_next;
      if (ir_load) begin
        instr <= readdata;
      end
    end
  end

  a_state_legal: assert property (@(posedge clk) disable iff (reset)
    state inside {FETCH, LOAD, MEM, EXEC, HALT});

endmodule

`default_nettype wire

/* hdl/control.sv */
// control decoder turning cpu state and instruction fields into bus strobes and datapath selects
`default_nettype none
`include "mips_cfg.svh"

module control import mips_isa_pkg::*, mips_ctrl_pkg::*; (
  input  logic       reset,
  input  opcode_t    opcode,           // instr[31:26]
  input  funct_t     function_code,    // instr[5:0]
  input  regimm_t    b_code,           // instr[20:16]
  input  cpu_state_t state,
  input  logic       waitrequest,      // bus stall
  input  logic [1:0] byte_addressing,  // low address bits of the data access

  // memory
  output logic       read,
  output logic       write,
  output wdata_sel_t write_data_sel,   // store lane placement
  output logic [3:0] byteenable,

  // register file
  output logic       [1:0] rd_select,  // 0 rt, 1 rd, 2 r31
  output logic       reg_write_enable,
  output load_sel_t  datamem_to_reg,
  output logic       link_to_reg,
  output logic       mfhi,
  output logic       mflo,
  output logic       lwl,
  output logic       lwr,

  // hi/lo
  output logic       hi_wren,
  output logic       lo_wren,
  output logic       multdiv,          // hi/lo take the mult/div result

  // alu
  output logic       imdt_sel,         // zero extend imm
  output logic       alu_src,          // 1 selects the immediate
  output alu_op_t    alu_op,

  // pc
  output logic       branch,
  output logic       jump,             // j, jal
  output logic       jumpreg           // jr, jalr
);

  cpu_state_t cur_state;
  logic       is_special;
  logic       is_link_regimm;
  logic       is_load;

  // state is unknown until the first reset edge so decode reset as the reset state
  assign cur_state = reset ? `MIPS_RESET_STATE : state;

  assign is_special     = (opcode == OP_SPECIAL);
  assign is_link_regimm = (opcode == OP_REGIMM) && (b_code inside {RI_BLTZAL, RI_BGEZAL});
  assign is_load = opcode inside {OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR};

  // bus command
  always_comb begin
    read           = 1'b0;
    write          = 1'b0;
    byteenable     = 4'b1111;
    write_data_sel = WD_WORD;
    case (cur_state)
      FETCH, LOAD: read = 1'b1;  // instruction read
      MEM: begin
        case (opcode)
          OP_SB: begin
            write = 1'b1;
            case (byte_addressing)  // one lane
              2'b00: begin
                byteenable     = 4'b0001;
                write_data_sel = WD_B0;
              end
              2'b01: begin
                byteenable     = 4'b0010;
                write_data_sel = WD_B1;
              end
              2'b10: begin
                byteenable     = 4'b0100;
                write_data_sel = WD_B2;
              end
              default: begin
                byteenable     = 4'b1000;
                write_data_sel = WD_B3;
              end
            endcase
          end
          OP_SH: begin
            write          = 1'b1;
            byteenable     = byte_addressing[1] ? 4'b1100 : 4'b0011;
            write_data_sel = byte_addressing[1] ? WD_H1 : WD_H0;
          end
          OP_SW: write = 1'b1;  // full word
          default: read = is_load;  // others idle through mem
        endcase
      end
      default: ;  // exec and halt keep the bus quiet
    endcase
  end

  // exec decode; every enable stays low in the other states
  always_comb begin
    rd_select        = 2'd0;
    reg_write_enable = 1'b0;
    datamem_to_reg   = LD_NONE;
    link_to_reg      = 1'b0;
    mfhi             = 1'b0;
    mflo             = 1'b0;
    lwl              = 1'b0;
    lwr              = 1'b0;
    hi_wren          = 1'b0;
    lo_wren          = 1'b0;
    multdiv          = 1'b0;
    imdt_sel         = 1'b0;
    alu_src          = 1'b1;      // mem address is base + imm
    alu_op           = ALU_ADDR;
    branch           = 1'b0;
    jump             = 1'b0;
    jumpreg          = 1'b0;
    if (cur_state == EXEC) begin
      case (opcode)
        OP_SPECIAL: rd_select = 2'd1;
        OP_JAL:     rd_select = 2'd2;
        OP_REGIMM:  rd_select = is_link_regimm ? 2'd2 : 2'd0;
        default:    rd_select = 2'd0;
      endcase

      case (opcode)
        OP_SPECIAL: reg_write_enable = !(function_code inside
          {FN_JR, FN_MTHI, FN_MTLO, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU});
        OP_REGIMM:  reg_write_enable = is_link_regimm;
        OP_JAL, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
          reg_write_enable = 1'b1;
        default:    reg_write_enable = is_load;
      endcase

      case (opcode)
        OP_LW, OP_LWL, OP_LWR: datamem_to_reg = LD_WORD;  // merge done downstream
        OP_LB:  datamem_to_reg = LD_BYTE;
        OP_LBU: datamem_to_reg = LD_BYTEU;
        OP_LH:  datamem_to_reg = LD_HALF;
        OP_LHU: datamem_to_reg = LD_HALFU;
        default: datamem_to_reg = LD_NONE;
      endcase

      link_to_reg = (opcode == OP_JAL) || is_link_regimm ||
                    (is_special && function_code == FN_JALR);
      mfhi = is_special && (function_code == FN_MFHI);
      mflo = is_special && (function_code == FN_MFLO);
      lwl  = (opcode == OP_LWL);
      lwr  = (opcode == OP_LWR);

      multdiv = is_special && (function_code inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU});
      hi_wren = multdiv || (is_special && function_code == FN_MTHI);
      lo_wren = multdiv || (is_special && function_code == FN_MTLO);

      imdt_sel = opcode inside {OP_ANDI, OP_ORI, OP_XORI};
      alu_src  = !(opcode inside {OP_SPECIAL, OP_BEQ, OP_BNE});  // register operand b

      case (opcode)
        OP_SPECIAL:     alu_op = ALU_RTYPE;
        OP_BEQ, OP_BNE: alu_op = ALU_BRANCH;
        OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
          alu_op = ALU_ITYPE;
        default:        alu_op = ALU_ADDR;
      endcase

      branch  = opcode inside {OP_REGIMM, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ};
      jump    = opcode inside {OP_J, OP_JAL};
      jumpreg = is_special && (function_code inside {FN_JR, FN_JALR});
    end
  end

  // sampled where the slave releases a stalled command
  a_one_cmd: assert property (@(negedge waitrequest) disable iff (reset)
    !(read && write));

  a_be_legal: assert property (@(negedge waitrequest) disable iff (reset)
    byteenable inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111});

endmodule

`default_nettype wire

/* hdl/store_lane_formatter.sv */
// store lane formatter placing rt data on the byte lanes picked by the decoder
`default_nettype none
`include "mips_cfg.svh"

module store_lane_formatter import mips_ctrl_pkg::*; (
  input  wdata_sel_t              write_data_sel,
  input  logic [`MIPS_DATA_W-1:0] rt_data,
  output logic [`MIPS_DATA_W-1:0] writedata
);

  always_comb begin
    writedata = '0;  // unused lanes read as zero
    case (write_data_sel)
      WD_B0:   writedata[7:0]   = rt_data[7:0];
      WD_B1:   writedata[15:8]  = rt_data[7:0];
      WD_B2:   writedata[23:16] = rt_data[7:0];
      WD_B3:   writedata[31:24] = rt_data[7:0];
      WD_H0:   writedata[15:0]  = rt_data[15:0];
      WD_H1:   writedata[31:16] = rt_data[15:0];  // sh at offset 2
      default: writedata        = rt_data;        // sw
    endcase
  end

endmodule

`default_nettype wire

/* hdl/load_data_extender.sv */
// load data extender holding the memory data register and forming the load writeback value
`default_nettype none
`include "mips_cfg.svh"

module load_data_extender import mips_ctrl_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    mdr_load,        // last mem read cycle
  input  logic [`MIPS_DATA_W-1:0] readdata,
  input  load_sel_t               datamem_to_reg,
  input  logic                    lwl,
  input  logic                    lwr,
  input  logic [1:0]              byte_addressing,
  input  logic [`MIPS_DATA_W-1:0] rt_old,          // rt before the load
  output logic [`MIPS_DATA_W-1:0] reg_write_data   // valid in exec
);

  logic [`MIPS_DATA_W-1:0] mdr;
  logic [7:0]              byte_sel;
  logic [15:0]             half_sel;
  logic [`MIPS_DATA_W-1:0] lwl_merge;
  logic [`MIPS_DATA_W-1:0] lwr_merge;

  always_ff @(posedge clk) begin
    if (reset) begin
      mdr <= '0;
    end else if (mdr_load) begin
      mdr <= readdata;
    end
  end

  assign byte_sel = mdr[8*byte_addressing +: 8];                     // little endian lane
  assign half_sel = byte_addressing[1] ? mdr[31:16] : mdr[15:0];

  // lwl fills rt from the top down with bytes up to the addressed one
  always_comb begin
    case (byte_addressing)
      2'b00:   lwl_merge = {mdr[7:0], rt_old[23:0]};
      2'b01:   lwl_merge = {mdr[15:0], rt_old[15:0]};
      2'b10:   lwl_merge = {mdr[23:0], rt_old[7:0]};
      default: lwl_merge = mdr;
    endcase
  end

  // lwr fills rt from the bottom up with bytes from the addressed one
  always_comb begin
    case (byte_addressing)
      2'b00:   lwr_merge = mdr;
      2'b01:   lwr_merge = {rt_old[31:24], mdr[31:8]};
      2'b10:   lwr_merge = {rt_old[31:16], mdr[31:16]};
      default: lwr_merge = {rt_old[31:8], mdr[31:24]};
    endcase
  end

  always_comb begin
    case (datamem_to_reg)
      LD_WORD: begin
        if (lwl) begin
          reg_write_data = lwl_merge;
        end else if (lwr) begin
          reg_write_data = lwr_merge;
        end else begin
          reg_write_data = mdr;
        end
      end
      LD_BYTE:  reg_write_data = {{24{byte_sel[7]}}, byte_sel};   // sign extend
      LD_BYTEU: reg_write_data = {24'b0, byte_sel};
      LD_HALF:  reg_write_data = {{16{half_sel[15]}}, half_sel};
      LD_HALFU: reg_write_data = {16'b0, half_sel};
      default:  reg_write_data = '0;  // not a load
    endcase
  end

endmodule

`default_nettype wire

/* hdl/mips_control_path.sv */
// mips control path top joining sequencer, decoder, store formatter and load extender
`default_nettype none
`include "mips_cfg.svh"

module mips_control_path import mips_isa_pkg::*, mips_ctrl_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,

  // memory bus
  input  logic                    waitrequest,
  input  logic [`MIPS_DATA_W-1:0] readdata,
  output logic                    read,
  output logic                    write,
  output logic [3:0]              byteenable,
  output logic [`MIPS_DATA_W-1:0] writedata,

  // from the datapath
  input  logic [1:0]              byte_addressing,  // alu result [1:0]
  input  logic [`MIPS_DATA_W-1:0] rt_data,
  input  logic [`MIPS_DATA_W-1:0] rt_old,

  // register file selects
  output logic [1:0]              rd_select,
  output logic                    reg_write_enable,
  output load_sel_t               datamem_to_reg,
  output logic                    link_to_reg,
  output logic                    mfhi,
  output logic                    mflo,
  output logic                    lwl,
  output logic                    lwr,

  // hi/lo selects
  output logic                    hi_wren,
  output logic                    lo_wren,
  output logic                    multdiv,

  // alu selects
  output logic                    imdt_sel,
  output logic                    alu_src,
  output alu_op_t                 alu_op,

  // pc selects
  output logic                    branch,
  output logic                    jump,
  output logic                    jumpreg,

  output logic [`MIPS_DATA_W-1:0] reg_write_data,
  output cpu_state_t              state
);

  logic [31:0] instr;           // current instruction
  logic        mdr_load;
  wdata_sel_t  write_data_sel;  // decoder to store formatter

  cpu_state_fsm i_cpu_state_fsm (
    .clk         (clk),
    .reset       (reset),
    .waitrequest (waitrequest),
    .readdata    (readdata),
    .read        (read),
    .write       (write),
    .state       (state),
    .instr       (instr),
    .mdr_load    (mdr_load)
  );

  control i_control (
    .reset            (reset),
    .opcode           (opcode_t'(instr[31:26])),
    .function_code    (funct_t'(instr[5:0])),
    .b_code           (regimm_t'(instr[20:16])),
    .state            (state),
    .waitrequest      (waitrequest),
    .byte_addressing  (byte_addressing),
    .read             (read),
    .write            (write),
    .write_data_sel   (write_data_sel),
    .byteenable       (byteenable),
    .rd_select        (rd_select),
    .reg_write_enable (reg_write_enable),
    .datamem_to_reg   (datamem_to_reg),
    .link_to_reg      (link_to_reg),
    .mfhi             (mfhi),
    .mflo             (mflo),
    .lwl              (lwl),
    .lwr              (lwr),
    .hi_wren          (hi_wren),
    .lo_wren          (lo_wren),
    .multdiv          (multdiv),
    .imdt_sel         (imdt_sel),
    .alu_src          (alu_src),
    .alu_op           (alu_op),
    .branch           (branch),
    .jump             (jump),
    .jumpreg          (jumpreg)
  );

  store_lane_formatter i_store_lane_formatter (
    .write_data_sel (write_data_sel),
    .rt_data        (rt_data),
    .writedata      (writedata)
  );

  load_data_extender i_load_data_extender (
    .clk             (clk),
    .reset           (reset),
    .mdr_load        (mdr_load),
    .readdata        (readdata),
    .datamem_to_reg  (datamem_to_reg),
    .lwl             (lwl),
    .lwr             (lwr),
    .byte_addressing (byte_addressing),
    .rt_old          (rt_old),
    .reg_write_data  (reg_write_data)
  );

endmodule

`default_nettype wire

/* test/tb_mips_control_path.sv */
// self-checking testbench acting as the memory of the mips control path and replaying vectors
`default_nettype none
`include "mips_cfg.svh"

module tb_mips_control_path import mips_ctrl_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_VEC = 27;  // vectors in the data file
  localparam int VEC_W   = 10;  // words per vector
  localparam int MAX_WAIT = 16; // cycles before a wait gives up

  logic                    clk;
  logic                    reset;
  logic                    waitrequest;
  logic [`MIPS_DATA_W-1:0] readdata;
  logic                    read;
  logic                    write;
  logic [3:0]              byteenable;
  logic [`MIPS_DATA_W-1:0] writedata;
  logic [1:0]              byte_addressing;
  logic [`MIPS_DATA_W-1:0] rt_data;
  logic [`MIPS_DATA_W-1:0] rt_old;
  logic [1:0]              rd_select;
  logic                    reg_write_enable;
  load_sel_t               datamem_to_reg;
  logic                    link_to_reg;
  logic                    mfhi;
  logic                    mflo;
  logic                    lwl;
  logic                    lwr;
  logic                    hi_wren;
  logic                    lo_wren;
  logic                    multdiv;
  logic                    imdt_sel;
  logic                    alu_src;
  alu_op_t                 alu_op;
  logic                    branch;
  logic                    jump;
  logic                    jumpreg;
  logic [`MIPS_DATA_W-1:0] reg_write_data;
  cpu_state_t              state;

  logic [31:0] vec_mem [0:NUM_VEC*VEC_W-1];  // instr rt_data rt_old ba load be wd we rwd flags
  int          errors;
  int          vec_errors;
  bit          timed_out;

  mips_control_path i_mips_control_path (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;  // 40 ns period

  // flag word as packed in the data file
  function automatic logic [15:0] flag_word();
    return {1'b0, rd_select, alu_op, alu_src, imdt_sel, link_to_reg, mfhi, mflo,
            hi_wren, lo_wren, multdiv, branch, jump, jumpreg};
  endfunction

  function automatic logic [15:0] enable_word();
    return 16'({reg_write_enable, hi_wren, lo_wren, multdiv, link_to_reg, mfhi, mflo,
                lwl, lwr, branch, jump, jumpreg});
  endfunction

  // write back form that a load opcode calls for
  function automatic load_sel_t load_form(input logic [5:0] op);
    case (op)
      6'h20:               return LD_BYTE;   // lb
      6'h24:               return LD_BYTEU;  // lbu
      6'h21:               return LD_HALF;   // lh
      6'h25:               return LD_HALFU;  // lhu
      6'h22, 6'h23, 6'h26: return LD_WORD;   // lwl, lw, lwr
      default:             return LD_NONE;
    endcase
  endfunction

  task automatic check_word(input string name, input logic [`MIPS_DATA_W-1:0] got,
                            input logic [`MIPS_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bits(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_alu_op(input alu_op_t got, input alu_op_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED alu_op got %h expected %h", got, exp);
      errors++;
    end
  endtask

  task automatic check_load_sel(input load_sel_t got, input load_sel_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED datamem_to_reg got %h expected %h", got, exp);
      errors++;
    end
  endtask

  task automatic check_state(input cpu_state_t got, input cpu_state_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED state got %h expected %h", got, exp);
      errors++;
    end
  endtask

  // one clock ending at the falling edge where outputs are settled
  task automatic step();
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic wait_for_state(input cpu_state_t s, output bit ok);
    ok = 1'b0;
    for (int n = 0; n < MAX_WAIT; n++) begin
      if (state == s) begin
        ok = 1'b1;
        break;
      end
      step();
    end
    if (!ok) begin
      $display("timeout: the DUT never reached state %s", s.name());
    end
  endtask

  // stall the bus then release it for one edge while returning data
  task automatic serve_access(input cpu_state_t s, input logic [31:0] data,
                              input logic [15:0] cmd);
    int stall;
    stall = $urandom_range(3, 0);
    for (int k = 0; k <= stall; k++) begin
      check_state(state, s);  // held by waitrequest
      check_bits("bus command", 16'({read, write, byteenable}), cmd);
      if (k < stall) step();
    end
    @(posedge clk);
    waitrequest <= 1'b0;
    readdata    <= data;
    @(negedge clk);
    check_state(state, s);
    check_bits("bus command", 16'({read, write, byteenable}), cmd);
    @(posedge clk);
    waitrequest <= 1'b1;  // idle bus stalls by default
    @(negedge clk);
  endtask

  task automatic run_vector(input int v, output bit ok);
    logic [31:0] w [VEC_W];
    logic        is_load;
    logic        is_store;
    for (int k = 0; k < VEC_W; k++) w[k] = vec_mem[v*VEC_W+k];
    is_load  = w[0][31:26] inside {6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26};
    is_store = w[0][31:26] inside {6'h28, 6'h29, 6'h2B};
    wait_for_state(FETCH, ok);
    if (!ok) return;
    @(posedge clk);
    rt_data         <= w[1];
    rt_old          <= w[2];
    byte_addressing <= w[3][1:0];
    @(negedge clk);
    check_bits("fetch enables", enable_word(), 16'h0);
    serve_access(FETCH, w[0], 16'h2F);  // read, all lanes
    check_state(state, LOAD);
    step();
    wait_for_state(MEM, ok);
    if (!ok) return;
    check_bits("byteenable", 16'(byteenable), w[5][15:0]);
    check_word("writedata", writedata, w[6]);
    if (is_load || is_store) begin
      serve_access(MEM, w[4], 16'({is_load, is_store, w[5][3:0]}));
    end else begin
      check_bits("mem idle", 16'({read, write}), 16'h0);
      step();  // one cycle without an access
    end
    check_state(state, EXEC);
    check_bits("reg_write_enable", 16'(reg_write_enable), w[7][15:0]);
    check_word("reg_write_data", reg_write_data, w[8]);
    check_bits("flags", flag_word(), w[9][15:0]);
    check_alu_op(alu_op, alu_op_t'(w[9][12:11]));
    check_load_sel(datamem_to_reg, load_form(w[0][31:26]));
    check_bits("lwl lwr", 16'({lwl, lwr}),
               16'({w[0][31:26] == 6'h22, w[0][31:26] == 6'h26}));
    step();
  endtask

  initial begin
    bit ok;
    errors    = 0;
    timed_out = 1'b0;
    void'($urandom(64908));  // seeds the stall lengths
    reset           <= 1'b1;
    waitrequest     <= 1'b1;
    readdata        <= '0;
    byte_addressing <= 2'b00;
    rt_data         <= '0;
    rt_old          <= '0;
    $readmemh("test/mips_testdata.txt", vec_mem);
    for (int c = 0; c < 10; c++) begin
      @(negedge clk);
      check_bits("reset bus", 16'({read, write, byteenable}), 16'h2F);
      check_bits("reset enables", enable_word(), 16'h0);
      @(posedge clk);
    end
    reset <= 1'b0;
    @(negedge clk);
    check_state(state, FETCH);
    for (int v = 0; v < NUM_VEC; v++) begin
      vec_errors = errors;
      run_vector(v, ok);
      if (!ok) begin
        timed_out = 1'b1;
        break;
      end
      $display("vector %0d instr %h: %s", v, vec_mem[v*VEC_W],
               (errors == vec_errors) ? "ok" : "mismatch");
    end
    $display("checks done, %0d errors, timeout %0d", errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/mips_testdata.txt */
// instr rt_data rt_old byte_addr loaddata | expected byteenable writedata reg_we reg_wdata flags
// flags [14:13] rd_select [12:11] alu_op [10] alu_src [9] imdt [8] link [7:0] mfhi..jumpreg
A0220000 A1B2C3D4 00000000 0 00000000 1 000000D4 0 00000000 0400
A0220001 A1B2C3D4 00000000 1 00000000 2 0000D400 0 00000000 0400
A0220002 A1B2C3D4 00000000 2 00000000 4 00D40000 0 00000000 0400
A0220003 A1B2C3D4 00000000 3 00000000 8 D4000000 0 00000000 0400
A4220000 A1B2C3D4 00000000 0 00000000 3 0000C3D4 0 00000000 0400
A4220002 A1B2C3D4 00000000 2 00000000 C C3D40000 0 00000000 0400
AC220000 A1B2C3D4 00000000 0 00000000 F A1B2C3D4 0 00000000 0400
80220001 A1B2C3D4 55667788 1 8899AABB F A1B2C3D4 1 FFFFFFAA 0400
90220003 A1B2C3D4 55667788 3 8899AABB F A1B2C3D4 1 00000088 0400
84220002 A1B2C3D4 55667788 2 8899AABB F A1B2C3D4 1 FFFF8899 0400
94220000 A1B2C3D4 55667788 0 8899AABB F A1B2C3D4 1 0000AABB 0400
8C220000 A1B2C3D4 55667788 0 8899AABB F A1B2C3D4 1 8899AABB 0400
88220001 A1B2C3D4 55667788 1 8899AABB F A1B2C3D4 1 AABB7788 0400
98220002 A1B2C3D4 55667788 2 8899AABB F A1B2C3D4 1 55668899 0400
00221821 A1B2C3D4 00000000 0 00000000 F A1B2C3D4 1 00000000 3000
302200FF A1B2C3D4 00000000 0 00000000 F A1B2C3D4 1 00000000 1E00
34220001 A1B2C3D4 00000000 0 00000000 F A1B2C3D4 1 00000000 1E00
24220010 A1B2C3D4 00000000 0 00000000 F A1B2C3D4 1 00000000 1C00
00220018 A1B2C3D4 00000000 0 00000000 F A1B2C3D4 0 00000000 3038
0022001A A1B2C3D4 00000000 0 00000000 F A1B2C3D4 0 00000000 3038
00001810 A1B2C3D4 00000000 0 00000000 F A1B2C3D4 1 00000000 3080
10220004 A1B2C3D4 00000000 0 00000000 F A1B2C3D4 0 00000000 0804
04310004 A1B2C3D4 00000000 0 00000000 F A1B2C3D4 1 00000000 4504
08000010 A1B2C3D4 00000000 0 00000000 F A1B2C3D4 0 00000000 0402
0C000010 A1B2C3D4 00000000 0 00000000 F A1B2C3D4 1 00000000 4502
00200008 A1B2C3D4 00000000 0 00000000 F A1B2C3D4 0 00000000 3001
0020F809 A1B2C3D4 00000000 0 00000000 F A1B2C3D4 1 00000000 3101

/* files.f */
+incdir+include
hdl/mips_isa_pkg.sv
hdl/mips_ctrl_pkg.sv
hdl/cpu_state_fsm.sv
hdl/control.sv
hdl/store_lane_formatter.sv
hdl/load_data_extender.sv
hdl/mips_control_path.sv
test/tb_mips_control_path.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module tb_mips_control_path -o tb_sim
	./obj_dir/tb_sim | tee /dev/stderr | grep -q "\*\*\* TEST PASSED \*\*\*"

clean:
	rm -rf obj_dir
